/* hw/byte_unpacker.sv */
/*
 * Byte unpacker
 * Splits strobed input words into bytes and accepts each word at its last byte
 */
`timescale 1ns/10ps
`default_nettype none

module byte_unpacker
#(
    parameter int IN_BYTES = 4
)
(
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 in_valid_i,
    input  logic [IN_BYTES*jpeg_pkg::BYTE_W-1:0] in_data_i,
    input  logic [IN_BYTES-1:0]                  in_strb_i,
    input  logic                                 in_last_i,
    input  logic                                 byte_take_i,
    output jpeg_pkg::byte_stream_t               byte_o,
    output logic                                 in_accept_o
);
    import jpeg_pkg::*;

    localparam int IDX_W = (IN_BYTES > 1) ? $clog2(IN_BYTES) : 1;

    logic [IDX_W-1:0]    idx_q;
    logic [IN_BYTES-1:0] strb_rest_w;
    logic                final_w;
    logic                take_w;

    // Strobes from the current byte upwards
    assign strb_rest_w = in_strb_i >> idx_q;

    // Top byte of the word, or highest strobed byte of a last word
    assign final_w = (idx_q == IDX_W'(IN_BYTES - 1)) ||
                     (in_last_i && ((strb_rest_w >> 1) == '0));

    assign take_w      = in_valid_i && byte_take_i;
    assign in_accept_o = take_w && final_w;

    // Current byte, zero where the strobe is clear
    always_comb
    begin
        byte_o.valid = in_valid_i;
        byte_o.data  = in_strb_i[idx_q] ? in_data_i[idx_q*BYTE_W +: BYTE_W] : '0;
        byte_o.last  = in_last_i && final_w;
    end

    // Byte index within the word
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            idx_q <= '0;
        else if (take_w)
            idx_q <= final_w ? '0 : idx_q + IDX_W'(1);
    end

    // Source holds a word until its last byte is taken
    a_word_held: assert property (@(posedge clk_i) disable iff (rst_i)
        idx_q != '0 |-> in_valid_i);

endmodule

`default_nettype wire

/* hw/entropy_unstuff.sv */
/*
 * Entropy data unstuffer
 * Turns FF 00 into FF and flags the final scan byte at EOI
 */
`timescale 1ns/10ps
`default_nettype none

module entropy_unstuff
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  jpeg_pkg::byte_stream_t scan_i,
    input  logic                   scan_end_i,
    input  logic                   scan_accept_i,
    output jpeg_pkg::byte_stream_t scan_o,
    output logic                   scan_ready_o
);
    import jpeg_pkg::*;

    logic [BYTE_W-1:0] hold_q;
    logic              hold_v_q;
    logic              pend_q;
    logic              is_ff_w;
    logic              new_w;
    logic              flush_w;

    assign is_ff_w = (scan_i.data == 8'hFF);
    // Next data byte, a literal FF after a pending FF
    assign new_w   = scan_i.valid && !scan_i.last && !is_ff_w;
    // Stream cut mid scan, drop what is held
    assign flush_w = scan_i.valid && scan_i.last;

    // Held byte leaves when its successor or EOI shows up
    always_comb
    begin
        scan_o.valid = hold_v_q && (new_w || scan_end_i);
        scan_o.data  = hold_q;
        scan_o.last  = scan_end_i;
    end

    assign scan_ready_o = !scan_o.valid || scan_accept_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            hold_v_q <= 1'b0;
            pend_q   <= 1'b0;
        end
        else if (scan_ready_o)
        begin
            if (scan_end_i || flush_w)
            begin
                hold_v_q <= 1'b0;
                pend_q   <= 1'b0;
            end
            else if (scan_i.valid)
            begin
                // FF fill bytes keep the flag set
                if (is_ff_w)
                    pend_q <= 1'b1;
                else
                begin
                    hold_v_q <= 1'b1;
                    pend_q   <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (scan_ready_o && new_w)
            hold_q <= pend_q ? 8'hFF : scan_i.data;
    end

    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        scan_o.valid && !scan_accept_i |=> scan_o.valid && $stable(scan_o.data));

endmodule

`default_nettype wire

/* hw/jpeg_input_top.sv */
/*
 * JPEG marker parser top
 * Word stream in, table bytes, header info and scan bytes out
 */
`timescale 1ns/10ps
`default_nettype none

module jpeg_input_top
#(
    parameter int IN_BYTES = 4
)
(
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    // Word input
    input  logic                                 inport_valid_i,
    input  logic [IN_BYTES*jpeg_pkg::BYTE_W-1:0] inport_data_i,
    input  logic [IN_BYTES-1:0]                  inport_strb_i,
    input  logic                                 inport_last_i,
    output logic                                 inport_accept_o,
    // Table and scan byte outputs
    output jpeg_pkg::byte_stream_t               dqt_o,
    input  logic                                 dqt_accept_i,
    output jpeg_pkg::byte_stream_t               dht_o,
    input  logic                                 dht_accept_i,
    output jpeg_pkg::byte_stream_t               scan_o,
    input  logic                                 scan_accept_i,
    // Image status
    output jpeg_pkg::img_info_t                  img_info_o,
    output logic                                 img_active_o
);
    import jpeg_pkg::*;

    byte_stream_t byte_w;
    byte_stream_t sof_w;
    byte_stream_t fsm_scan_w;
    marker_t      marker_w;
    logic         byte_take_w;
    logic         sof_start_w;
    logic         sof_end_w;
    logic         scan_end_w;
    logic         scan_ready_w;

    byte_unpacker #(
        .IN_BYTES (IN_BYTES)
    ) i_unpack (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (inport_valid_i),
        .in_data_i   (inport_data_i),
        .in_strb_i   (inport_strb_i),
        .in_last_i   (inport_last_i),
        .byte_take_i (byte_take_w),
        .byte_o      (byte_w),
        .in_accept_o (inport_accept_o)
    );

    marker_detect i_marker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .byte_i      (byte_w),
        .byte_take_i (byte_take_w),
        .marker_o    (marker_w)
    );

    segment_fsm i_fsm (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .byte_i       (byte_w),
        .marker_i     (marker_w),
        .dqt_accept_i (dqt_accept_i),
        .dht_accept_i (dht_accept_i),
        .scan_ready_i (scan_ready_w),
        .byte_take_o  (byte_take_w),
        .dqt_o        (dqt_o),
        .dht_o        (dht_o),
        .sof_o        (sof_w),
        .scan_o       (fsm_scan_w),
        .sof_start_o  (sof_start_w),
        .sof_end_o    (sof_end_w),
        .scan_end_o   (scan_end_w),
        .active_o     (img_active_o)
    );

    sof_capture i_sof (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sof_i       (sof_w),
        .sof_start_i (sof_start_w),
        .sof_end_i   (sof_end_w),
        .info_o      (img_info_o)
    );

    entropy_unstuff i_unstuff (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .scan_i        (fsm_scan_w),
        .scan_end_i    (scan_end_w),
        .scan_accept_i (scan_accept_i),
        .scan_o        (scan_o),
        .scan_ready_o  (scan_ready_w)
    );

endmodule

`default_nettype wire

/* hw/jpeg_pkg.sv */
/*
 * JPEG marker parser shared types
 * Byte stream, marker classes, parser states and image info
 */
`default_nettype none

package jpeg_pkg;

    // Basic widths
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 16;

    // Byte stream between stages and on the byte outputs
    typedef struct packed {
        logic              valid;
        logic [BYTE_W-1:0] data;
        logic              last;
    } byte_stream_t;

    // Marker class of the current byte pair
    typedef enum logic [3:0] {
        MK_NONE,
        MK_SOI,
        MK_EOI,
        MK_SOF0,
        MK_DQT,
        MK_DHT,
        MK_SOS,
        MK_PAD,     // FF 00 stuffing
        MK_SKIP     // SOF2, DRI, RSTn, APPn, COM
    } marker_t;

    // Parser states, one payload state per segment kind
    typedef enum logic [4:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_LENH,
        ST_LENL,
        ST_SOS_HDR,
        ST_SCAN,
        ST_DQT_DATA,
        ST_DHT_DATA,
        ST_SOF_DATA,
        ST_SKIP_DATA
    } seg_state_t;

    // Payload routing
    typedef enum logic [1:0] {
        KIND_DQT,
        KIND_DHT,
        KIND_SOF,
        KIND_SKIP
    } seg_kind_t;

    typedef enum logic [1:0] {
        MODE_MONO,
        MODE_YCBCR_444,
        MODE_YCBCR_420,
        MODE_UNSUPPORTED
    } img_mode_t;

    // SOF0 header summary
    typedef struct packed {
        logic [LEN_W-1:0] width;
        logic [LEN_W-1:0] height;
        img_mode_t        mode;
        logic [1:0]       dqt_y;
        logic [1:0]       dqt_cb;
        logic [1:0]       dqt_cr;
    } img_info_t;

endpackage

`default_nettype wire

/* hw/marker_detect.sv */
/*
 * Marker detector
 * Classifies the previous and current byte as a JPEG marker code
 */
`timescale 1ns/10ps
`default_nettype none

module marker_detect
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  jpeg_pkg::byte_stream_t byte_i,
    input  logic                   byte_take_i,
    output jpeg_pkg::marker_t      marker_o
);
    import jpeg_pkg::*;

    logic [BYTE_W-1:0] prev_q;

    // Previous taken byte, cleared at end of stream
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            prev_q <= '0;
        else if (byte_i.valid && byte_take_i)
            prev_q <= byte_i.last ? '0 : byte_i.data;
    end

    // Code table, only after an FF
    always_comb
    begin
        marker_o = MK_NONE;
        if (byte_i.valid && prev_q == 8'hFF)
        begin
            case (byte_i.data) inside
                8'hD8:   marker_o = MK_SOI;
                8'hD9:   marker_o = MK_EOI;
                8'hC0:   marker_o = MK_SOF0;
                8'hDB:   marker_o = MK_DQT;
                8'hC4:   marker_o = MK_DHT;
                8'hDA:   marker_o = MK_SOS;
                8'h00:   marker_o = MK_PAD;
                // SOF2, DRI, COM, RSTn and APPn
                8'hC2, 8'hDD, 8'hFE, [8'hD0:8'hD7], [8'hE0:8'hEF]:
                    marker_o = MK_SKIP;
                // FF fill bytes and unknown codes
                default: marker_o = MK_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/segment_fsm.sv */
/*
 * Segment FSM
 * Walks marker segments, counts lengths and routes payload bytes
 */
`timescale 1ns/10ps
`default_nettype none

module segment_fsm
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  jpeg_pkg::byte_stream_t byte_i,
    input  jpeg_pkg::marker_t      marker_i,
    input  logic                   dqt_accept_i,
    input  logic                   dht_accept_i,
    input  logic                   scan_ready_i,
    output logic                   byte_take_o,
    output jpeg_pkg::byte_stream_t dqt_o,
    output jpeg_pkg::byte_stream_t dht_o,
    output jpeg_pkg::byte_stream_t sof_o,
    output jpeg_pkg::byte_stream_t scan_o,
    output logic                   sof_start_o,
    output logic                   sof_end_o,
    output logic                   scan_end_o,
    output logic                   active_o
);
    import jpeg_pkg::*;

    seg_state_t       state_q, state_d;
    seg_kind_t        kind_q;
    logic             sos_q;
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] len_load_w;
    logic             pay_last_w;
    logic             take_ok_w;
    logic             take_w;
    byte_stream_t     pay_w;

    // Segment length less the two length bytes
    assign len_load_w = {len_q[LEN_W-1:BYTE_W], byte_i.data} - LEN_W'(2);
    assign pay_last_w = (len_q == LEN_W'(1));

    // --------------------------------------------------
    // Byte handshake
    // --------------------------------------------------
    always_comb
    begin
        case (state_q)
            ST_DQT_DATA: take_ok_w = dqt_accept_i;
            ST_DHT_DATA: take_ok_w = dht_accept_i;
            ST_SCAN:     take_ok_w = scan_ready_i;
            default:     take_ok_w = 1'b1;
        endcase
    end

    assign take_w      = byte_i.valid && take_ok_w;
    assign byte_take_o = take_w;

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (marker_i == MK_SOI)
                    state_d = ST_ACTIVE;
            ST_ACTIVE:
            begin
                case (marker_i)
                    MK_EOI:
                        state_d = ST_IDLE;
                    MK_DQT, MK_DHT, MK_SOF0, MK_SOS, MK_SKIP:
                        state_d = ST_LENH;
                    default:
                        state_d = ST_ACTIVE;
                endcase
            end
            ST_LENH:
                state_d = ST_LENL;
            ST_LENL:
            begin
                // Empty segments go straight on
                if (sos_q)
                    state_d = (len_load_w == '0) ? ST_SCAN : ST_SOS_HDR;
                else if (len_load_w == '0)
                    state_d = ST_ACTIVE;
                else
                begin
                    case (kind_q)
                        KIND_DQT: state_d = ST_DQT_DATA;
                        KIND_DHT: state_d = ST_DHT_DATA;
                        KIND_SOF: state_d = ST_SOF_DATA;
                        default:  state_d = ST_SKIP_DATA;
                    endcase
                end
            end
            ST_DQT_DATA, ST_DHT_DATA, ST_SOF_DATA, ST_SKIP_DATA:
                if (pay_last_w)
                    state_d = ST_ACTIVE;
            // Scan header is counted but not decoded
            ST_SOS_HDR:
                if (pay_last_w)
                    state_d = ST_SCAN;
            ST_SCAN:
                if (marker_i == MK_EOI)
                    state_d = ST_IDLE;
            default:
                state_d = ST_IDLE;
        endcase

        // End of input stream aborts any segment
        if (byte_i.last)
            state_d = ST_IDLE;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= ST_IDLE;
        else if (take_w)
            state_q <= state_d;
    end

    // Segment kind and length counter
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            kind_q <= KIND_SKIP;
            sos_q  <= 1'b0;
            len_q  <= '0;
        end
        else if (take_w)
        begin
            case (state_q)
                ST_ACTIVE:
                begin
                    sos_q <= (marker_i == MK_SOS);
                    case (marker_i)
                        MK_DQT:  kind_q <= KIND_DQT;
                        MK_DHT:  kind_q <= KIND_DHT;
                        MK_SOF0: kind_q <= KIND_SOF;
                        default: kind_q <= KIND_SKIP;
                    endcase
                end
                ST_LENH:
                    len_q <= {byte_i.data, {BYTE_W{1'b0}}};
                ST_LENL:
                    len_q <= len_load_w;
                ST_DQT_DATA, ST_DHT_DATA, ST_SOF_DATA, ST_SKIP_DATA, ST_SOS_HDR:
                    len_q <= len_q - LEN_W'(1);
                default:
                    ;
            endcase
        end
    end

    // --------------------------------------------------
    // Byte routing
    // --------------------------------------------------
    always_comb
    begin
        pay_w      = byte_i;
        pay_w.last = pay_last_w || byte_i.last;

        dqt_o       = pay_w;
        dqt_o.valid = pay_w.valid && (state_q == ST_DQT_DATA);
        dht_o       = pay_w;
        dht_o.valid = pay_w.valid && (state_q == ST_DHT_DATA);
        sof_o       = pay_w;
        sof_o.valid = pay_w.valid && (state_q == ST_SOF_DATA);

        // Scan keeps FF and the stuffing 00, drops marker codes
        scan_o       = byte_i;
        scan_o.valid = byte_i.valid && (state_q == ST_SCAN) &&
                       (marker_i == MK_NONE || marker_i == MK_PAD);
    end

    assign sof_start_o = take_w && (state_q == ST_ACTIVE) && (marker_i == MK_SOF0);
    assign sof_end_o   = take_w && (state_q == ST_SOF_DATA) && pay_last_w;
    // Presented, not taken, so the unstuffer's ready stays loop free
    assign scan_end_o  = byte_i.valid && (state_q == ST_SCAN) && (marker_i == MK_EOI);
    assign active_o    = (state_q != ST_IDLE);

    // Counted states always have bytes left
    a_len_live: assert property (@(posedge clk_i) disable iff (rst_i)
        state_q inside {ST_DQT_DATA, ST_DHT_DATA, ST_SOF_DATA, ST_SKIP_DATA, ST_SOS_HDR}
        |-> len_q != '0);

endmodule

`default_nettype wire

/* hw/sof_capture.sv */
/*
 * SOF0 capture
 * Picks the frame header fields and decides the colour mode
 */
`timescale 1ns/10ps
`default_nettype none

module sof_capture
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  jpeg_pkg::byte_stream_t sof_i,
    input  logic                   sof_start_i,
    input  logic                   sof_end_i,
    output jpeg_pkg::img_info_t    info_o
);
    import jpeg_pkg::*;

    localparam img_info_t INFO_CLR = '{width: '0, height: '0, mode: MODE_UNSUPPORTED,
                                       dqt_y: '0, dqt_cb: '0, dqt_cr: '0};
    // Sampling factor bytes, H in the high nibble
    localparam logic [BYTE_W-1:0] FAC_1X1 = 8'h11;
    localparam logic [BYTE_W-1:0] FAC_2X2 = 8'h22;

    logic [5:0]        idx_q;
    img_info_t         hdr_q, hdr_d;
    img_info_t         info_q;
    logic [BYTE_W-1:0] ncomp_q, ncomp_d;
    logic [BYTE_W-1:0] fy_q, fy_d;
    logic [BYTE_W-1:0] fcb_q, fcb_d;
    logic [BYTE_W-1:0] fcr_q, fcr_d;

    // Payload byte index, holds at the top
    always_ff @(posedge clk_i)
    begin
        if (rst_i || sof_start_i)
            idx_q <= '0;
        else if (sof_i.valid && idx_q != '1)
            idx_q <= idx_q + 6'd1;
    end

    // Header with the current byte applied
    always_comb
    begin
        hdr_d   = hdr_q;
        ncomp_d = ncomp_q;
        fy_d    = fy_q;
        fcb_d   = fcb_q;
        fcr_d   = fcr_q;
        if (sof_i.valid)
        begin
            case (idx_q)
                6'd1:    hdr_d.height[LEN_W-1:BYTE_W] = sof_i.data;
                6'd2:    hdr_d.height[BYTE_W-1:0]     = sof_i.data;
                6'd3:    hdr_d.width[LEN_W-1:BYTE_W]  = sof_i.data;
                6'd4:    hdr_d.width[BYTE_W-1:0]      = sof_i.data;
                6'd5:    ncomp_d                      = sof_i.data;
                // Per component: id, factors, table select
                6'd7:    fy_d                         = sof_i.data;
                6'd8:    hdr_d.dqt_y                  = sof_i.data[1:0];
                6'd10:   fcb_d                        = sof_i.data;
                6'd11:   hdr_d.dqt_cb                 = sof_i.data[1:0];
                6'd13:   fcr_d                        = sof_i.data;
                6'd14:   hdr_d.dqt_cr                 = sof_i.data[1:0];
                default: ;
            endcase
        end

        // Mode rule
        if (ncomp_d == 8'd1)
            hdr_d.mode = MODE_MONO;
        else if (ncomp_d == 8'd3 && fcb_d == FAC_1X1 && fcr_d == FAC_1X1 && fy_d == FAC_1X1)
            hdr_d.mode = MODE_YCBCR_444;
        else if (ncomp_d == 8'd3 && fcb_d == FAC_1X1 && fcr_d == FAC_1X1 && fy_d == FAC_2X2)
            hdr_d.mode = MODE_YCBCR_420;
        else
            hdr_d.mode = MODE_UNSUPPORTED;
    end

    // Working copy of the header
    always_ff @(posedge clk_i)
    begin
        if (sof_start_i)
        begin
            hdr_q   <= INFO_CLR;
            ncomp_q <= '0;
            fy_q    <= '0;
            fcb_q   <= '0;
            fcr_q   <= '0;
        end
        else if (sof_i.valid)
        begin
            hdr_q   <= hdr_d;
            ncomp_q <= ncomp_d;
            fy_q    <= fy_d;
            fcb_q   <= fcb_d;
            fcr_q   <= fcr_d;
        end
    end

    // Published at header end
    always_ff @(posedge clk_i)
    begin
        if (rst_i || sof_start_i)
            info_q <= INFO_CLR;
        else if (sof_end_i)
            info_q <= hdr_d;
    end

    assign info_o = info_q;

    a_end_on_last: assert property (@(posedge clk_i) disable iff (rst_i)
        sof_end_i |-> sof_i.valid && sof_i.last);

endmodule

`default_nettype wire

/* sources.f */
hw/jpeg_pkg.sv
hw/byte_unpacker.sv
hw/marker_detect.sv
hw/segment_fsm.sv
hw/sof_capture.sv
hw/entropy_unstuff.sv
hw/jpeg_input_top.sv
test/tb_jpeg_input.sv

/* test/jpeg_stream_input.txt */
# W word strobe last (first stream byte in bits 7:0) | Q/H/S data last for dqt_o, dht_o, scan_o
# I width height mode dqt_y dqt_cb dqt_cr, checked each time the image goes inactive
W E0FFD8FF F 0
W 22110400 F 0
W 0500DBFF F 0
W FF030201 F 0
W 100400C4 F 0
W 00FEFF20 F 0
W C0FF3303 F 0
W 00080B00 F 0
W 01200010 F 0
W FF011101 F 0
W 010300DA F 0
W 3400FF12 F 0
W AAD9FF56 7 1
Q 01 0
Q 02 0
Q 03 1
H 10 0
H 20 1
S 12 0
S FF 0
S 34 0
S 56 1
I 0020 0010 0 1 0 0
W DBFFD8FF F 0
W 55010800 7 1
Q 01 1
I 0020 0010 0 1 0 0
W C0FFD8FF F 0
W 00081100 F 0
W 03100008 F 0
W 02001101 F 0
W 11030111 F 0
W 77D9FF01 7 1
I 0010 0008 1 0 1 1
W C0FFD8FF F 0
W 00081100 F 0
W 03300020 F 0
W 02002201 F 0
W 11030111 F 0
W 00D9FF01 7 1
I 0030 0020 2 0 1 1
W C0FFD8FF F 0
W 01081100 F 0
W 03000200 F 0
W 02022101 F 0
W 11030311 F 0
W 00D9FF03 7 1
I 0200 0100 3 2 3 3

/* test/tb_jpeg_input.sv */
/*
 * JPEG marker parser testbench
 * Streams words from the data file and checks table, scan and header outputs
 */
`timescale 1ns/10ps
`default_nettype none

module tb_jpeg_input;
    import jpeg_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 16;
    localparam int          IN_BYTES     = 4;
    localparam logic [31:0] SEED         = 32'hf91f93b0;

    logic                   clk_i;
    logic                   rst_i;
    logic                   inport_valid_i;
    logic [IN_BYTES*8-1:0]  inport_data_i;
    logic [IN_BYTES-1:0]    inport_strb_i;
    logic                   inport_last_i;
    logic                   inport_accept_o;
    byte_stream_t           dqt_o;
    byte_stream_t           dht_o;
    byte_stream_t           scan_o;
    logic                   dqt_accept_i;
    logic                   dht_accept_i;
    logic                   scan_accept_i;
    img_info_t              img_info_o;
    logic                   img_active_o;

    // Stimulus and expected queues
    logic [IN_BYTES*8-1:0]  word_q[$];
    logic [IN_BYTES-1:0]    strb_q[$];
    logic                   last_q[$];
    byte_stream_t           dqt_exp[$];
    byte_stream_t           dht_exp[$];
    byte_stream_t           scan_exp[$];
    img_info_t              info_exp[$];

    int   cycle_cnt   = 0;
    int   cycle_limit = 0;
    int   dqt_cnt     = 0;
    int   dht_cnt     = 0;
    int   scan_cnt    = 0;
    int   img_cnt     = 0;
    logic active_q    = 1'b0;

    jpeg_input_top #(
        .IN_BYTES (IN_BYTES)
    ) i_dut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .inport_valid_i  (inport_valid_i),
        .inport_data_i   (inport_data_i),
        .inport_strb_i   (inport_strb_i),
        .inport_last_i   (inport_last_i),
        .inport_accept_o (inport_accept_o),
        .dqt_o           (dqt_o),
        .dqt_accept_i    (dqt_accept_i),
        .dht_o           (dht_o),
        .dht_accept_i    (dht_accept_i),
        .scan_o          (scan_o),
        .scan_accept_i   (scan_accept_i),
        .img_info_o      (img_info_o),
        .img_active_o    (img_active_o)
    );

    // --------------------------------------------------
    // Failure and compare helpers
    // --------------------------------------------------
    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input byte_stream_t exp_b,
                                input byte_stream_t act_b);
        if (act_b.data !== exp_b.data || act_b.last !== exp_b.last)
            end_with_failure($sformatf(
                "FAILED %s: expected data %h last %b, actual data %h last %b",
                name, exp_b.data, exp_b.last, act_b.data, act_b.last));
    endtask

    // Readable form of a header summary
    function automatic string info_text(input img_info_t info);
        return $sformatf("w %h h %h mode %0d q %0d/%0d/%0d", info.width, info.height,
                         info.mode, info.dqt_y, info.dqt_cb, info.dqt_cr);
    endfunction

    task automatic compare_info(input string name, input img_info_t exp_i,
                                input img_info_t act_i);
        if (act_i !== exp_i)
            end_with_failure($sformatf("FAILED %s: expected %s, actual %s",
                             name, info_text(exp_i), info_text(act_i)));
    endtask

    // Clock
    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // Random back-pressure, roughly one low cycle in four
    initial
    begin : back_pressure
        int unsigned seed_val;

        seed_val      = $urandom(SEED);
        dqt_accept_i  = 1'b0;
        dht_accept_i  = 1'b0;
        scan_accept_i = 1'b0;
        forever
        begin
            @(posedge clk_i);
            dqt_accept_i  <= ($urandom % 4) != 0;
            dht_accept_i  <= ($urandom % 4) != 0;
            scan_accept_i <= ($urandom % 4) != 0;
        end
    end

    // Cycle limit
    always @(posedge clk_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
            end_with_failure($sformatf("Timeout: stream not finished after %0d cycles", cycle_cnt));
    end

    // --------------------------------------------------
    // Output monitor
    // --------------------------------------------------
    always @(posedge clk_i)
    begin : monitor
        byte_stream_t exp_b;
        img_info_t    exp_i;

        active_q <= img_active_o;
        if (!rst_i)
        begin
            if (dqt_o.valid && dqt_accept_i)
            begin
                if (dqt_exp.size() == 0)
                    end_with_failure("Unexpected extra byte on dqt_o");
                exp_b = dqt_exp.pop_front();
                compare_byte($sformatf("dqt byte %0d", dqt_cnt), exp_b, dqt_o);
                dqt_cnt = dqt_cnt + 1;
            end
            if (dht_o.valid && dht_accept_i)
            begin
                if (dht_exp.size() == 0)
                    end_with_failure("Unexpected extra byte on dht_o");
                exp_b = dht_exp.pop_front();
                compare_byte($sformatf("dht byte %0d", dht_cnt), exp_b, dht_o);
                dht_cnt = dht_cnt + 1;
            end
            if (scan_o.valid && scan_accept_i)
            begin
                if (scan_exp.size() == 0)
                    end_with_failure("Unexpected extra byte on scan_o");
                exp_b = scan_exp.pop_front();
                compare_byte($sformatf("scan byte %0d", scan_cnt), exp_b, scan_o);
                scan_cnt = scan_cnt + 1;
            end
            // Header info once the image has ended
            if (active_q && !img_active_o)
            begin
                if (info_exp.size() == 0)
                    end_with_failure("img_active_o fell with no image expected");
                exp_i = info_exp.pop_front();
                compare_info($sformatf("image %0d info", img_cnt), exp_i, img_info_o);
                img_cnt = img_cnt + 1;
            end
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin : main_seq
        int                 fd;
        int                 c;
        int                 r;
        int                 idx;
        logic [31:0]        w;
        logic [3:0]         s;
        logic               l;
        logic [7:0]         d;
        logic [15:0]        wd;
        logic [15:0]        ht;
        logic [1:0]         m;
        logic [1:0]         qy;
        logic [1:0]         qcb;
        logic [1:0]         qcr;
        logic [8*128-1:0]   line_buf;
        byte_stream_t       b;
        img_info_t          inf;
        img_info_t          clr;

        rst_i          = 1'b1;
        inport_valid_i = 1'b0;
        inport_data_i  = '0;
        inport_strb_i  = '0;
        inport_last_i  = 1'b0;

        fd = $fopen("test/jpeg_stream_input.txt", "r");
        if (fd == 0)
            end_with_failure("Cannot open test/jpeg_stream_input.txt");
        c = $fgetc(fd);
        while (c != -1)
        begin
            case (c)
                "#": r = $fgets(line_buf, fd);
                "W":
                begin
                    r = $fscanf(fd, "%h %h %h", w, s, l);
                    word_q.push_back(w);
                    strb_q.push_back(s);
                    last_q.push_back(l);
                end
                "Q", "H", "S":
                begin
                    r = $fscanf(fd, "%h %h", d, l);
                    b.valid = 1'b1;
                    b.data  = d;
                    b.last  = l;
                    if (c == "Q")
                        dqt_exp.push_back(b);
                    else if (c == "H")
                        dht_exp.push_back(b);
                    else
                        scan_exp.push_back(b);
                end
                "I":
                begin
                    r = $fscanf(fd, "%h %h %h %h %h %h", wd, ht, m, qy, qcb, qcr);
                    inf.width  = wd;
                    inf.height = ht;
                    inf.mode   = img_mode_t'(m);
                    inf.dqt_y  = qy;
                    inf.dqt_cb = qcb;
                    inf.dqt_cr = qcr;
                    info_exp.push_back(inf);
                end
                default: ;
            endcase
            c = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = 8 * word_q.size() + 200;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        // State straight out of reset
        clr.width  = '0;
        clr.height = '0;
        clr.mode   = MODE_UNSUPPORTED;
        clr.dqt_y  = '0;
        clr.dqt_cb = '0;
        clr.dqt_cr = '0;
        compare_info("reset info", clr, img_info_o);
        if (inport_accept_o || img_active_o || dqt_o.valid || dht_o.valid || scan_o.valid)
            end_with_failure("Accept, active or a valid output is high after reset");

        // One word at a time, held until accepted
        for (idx = 0; idx < word_q.size(); idx++)
        begin
            inport_valid_i <= 1'b1;
            inport_data_i  <= word_q[idx];
            inport_strb_i  <= strb_q[idx];
            inport_last_i  <= last_q[idx];
            @(posedge clk_i);
            while (!inport_accept_o)
                @(posedge clk_i);
        end
        inport_valid_i <= 1'b0;
        inport_last_i  <= 1'b0;

        // Drain held scan bytes and pending header checks
        while (dqt_exp.size() != 0 || dht_exp.size() != 0 || scan_exp.size() != 0 ||
               info_exp.size() != 0)
            @(posedge clk_i);
        repeat (8) @(posedge clk_i);

        if (img_active_o)
            end_with_failure("Parser still active after the last image");
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
